// File: verification/risc_golden.txt
# columns: M addr data (preload) | I instr | S addr data (expected store, in order) | F carry zero
# all values hex
M 00000040 12345678
M 00000044 fedcba98
# li r1 0x80, li r2 25, li r3 -7, add r4 r2 r3, sw r4 0(r1)
I 7280
I 7419
I 77f9
I 1898
I 9840
S 00000080 00000012
# sub r5 r4 r2, sw r5 4(r1)
I 2b10
I 9a44
S 00000084 fffffff9
# and r6 r5 r2, or r7 r6 r4, xor r7 r7 r6, sw r7 8(r1), sw r6 12(r1)
I 3d50
I 4fa0
I 5ff0
I 9e48
I 9c4c
S 00000088 00000002
S 0000008c 00000019
# addi r2 r2 -1, sw r2 16(r1)
I 64bf
I 9450
S 00000090 00000018
# li r3 0x40, lw r4 0(r3), lw r5 4(r3), add r6 r4 r5 (stall), sw r6 20(r1)
I 7640
I 88c0
I 8ac4
I 1d28
I 9c54
S 00000094 11111110
# lw r7 8(r1) reads back a store, sub r7 r7 r2 (stall), sw r7 24(r1)
I 8e48
I 2fd0
I 9e58
S 00000098 ffffffea
# sub r5 r5 r5 sets carry and zero, sw r5 28(r1), then li, nop, undefined opcode
I 2b68
I 9a5c
S 0000009c 00000000
I 7400
I 0000
I f1ff
F 1 1

// File: tb.f
rtl/risc_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/exec_stage.sv
rtl/mem_wb_stage.sv
rtl/risc_top.sv
verification/risc_sva.sv
verification/risc_tb.sv

// File: Makefile
TOP := risc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim

clean:
	rm -rf obj_dir

// File: verification/risc_tb.sv
// run from the project root; reads verification/risc_golden.txt, dmem answers in the rd_en cycle
module risc_tb;

    logic                             risc_clk;
    logic                             risc_rst;
    logic [risc_pkg::INSTR_W-1:0]     instr_i;
    logic                             instr_valid_i;
    logic                             instr_ready_o;
    risc_pkg::dmem_req_t              dmem_req_o;
    logic [risc_pkg::DATA_W-1:0]      dmem_rdata_i;
    logic                             carry_o;
    logic                             zero_o;

    integer                           seed;          // gap generator state
    logic [risc_pkg::INSTR_W-1:0]     prog [$];      // instruction stream
    risc_pkg::dmem_req_t              exp_stores [$];
    risc_pkg::dmem_req_t              exp_st;
    logic [risc_pkg::DATA_W-1:0]      mem [logic [risc_pkg::DATA_W-1:0]];
    logic [risc_pkg::DATA_W-1:0]      exp_carry;
    logic [risc_pkg::DATA_W-1:0]      exp_zero;
    int                               n_stores;
    int                               store_cnt;
    int                               ready_low;     // cycles with instr_ready_o low
    int                               exp_stalls;
    int                               gap;
    int                               waited;

    risc_top i_dut (
        .risc_clk      (risc_clk),
        .risc_rst      (risc_rst),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .dmem_req_o    (dmem_req_o),
        .dmem_rdata_i  (dmem_rdata_i),
        .carry_o       (carry_o),
        .zero_o        (zero_o)
    );

    initial risc_clk = 1'b0;
    always #50 risc_clk = ~risc_clk;    // period 100

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic check_val(input string name,
                             input logic [risc_pkg::DATA_W-1:0] expected,
                             input logic [risc_pkg::DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [risc_pkg::DATA_W-1:0] bit_word(input logic b);
        logic [risc_pkg::DATA_W-1:0] w;
        w    = '0;
        w[0] = b;
        return w;
    endfunction

    // fill for untouched words depends on every address bit
    function automatic logic [risc_pkg::DATA_W-1:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'ha5a5_5a5a;
    endfunction

    // true when the isa field layout makes ins read register r
    function automatic logic reads_reg(input logic [15:0] ins, input logic [2:0] r);
        case (ins[15:12])
            risc_pkg::OP_ADD, risc_pkg::OP_SUB, risc_pkg::OP_AND,
            risc_pkg::OP_OR, risc_pkg::OP_XOR:
                return ins[8:6] == r || ins[5:3] == r;
            risc_pkg::OP_ADDI, risc_pkg::OP_LW:
                return ins[8:6] == r;
            risc_pkg::OP_SW:
                return ins[8:6] == r || ins[11:9] == r;    // base and data
            default:
                return 1'b0;                               // li, nop, undefined
        endcase
    endfunction

    // a lw is always followed without a gap, so each dependent successor costs one cycle
    function automatic int count_stalls();
        int n;
        n = 0;
        for (int i = 0; i + 1 < prog.size(); i++)
        begin
            if (prog[i][15:12] == risc_pkg::OP_LW && prog[i][11:9] != 3'd0
                && reads_reg(prog[i+1], prog[i][11:9]))
                n++;
        end
        return n;
    endfunction

    task automatic load_golden();
        int                          fd;
        int                          r;
        logic [7:0]                  tag;
        logic [1023:0]               skip;
        logic [risc_pkg::DATA_W-1:0] a;
        logic [risc_pkg::DATA_W-1:0] d;
        logic [risc_pkg::INSTR_W-1:0] ins;
        risc_pkg::dmem_req_t         st;
        fd = $fopen("verification/risc_golden.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open verification/risc_golden.txt");
            $display("Test failed");
            $fatal(1);
        end
        else
        begin
            r = $fscanf(fd, " %c", tag);
            while (r == 1)
            begin
                case (tag)
                    "#": r = $fgets(skip, fd);          // comment line
                    "M":
                    begin
                        r      = $fscanf(fd, "%h %h", a, d);
                        mem[a] = d;                     // preload
                    end
                    "I":
                    begin
                        r = $fscanf(fd, "%h", ins);
                        prog.push_back(ins);
                    end
                    "S":
                    begin
                        r        = $fscanf(fd, "%h %h", a, d);
                        st       = '0;
                        st.wr_en = 1'b1;
                        st.addr  = a;
                        st.wdata = d;
                        exp_stores.push_back(st);
                    end
                    "F": r = $fscanf(fd, "%h %h", exp_carry, exp_zero);
                    default:
                    begin
                        $display("unknown record type in golden file");
                        $display("Test failed");
                        $fatal(1);
                    end
                endcase
                r = $fscanf(fd, " %c", tag);
            end
            $fclose(fd);
        end
    endtask

    // holds the word until a rising edge sees ready and returns on the next falling edge
    task automatic send_instr(input logic [risc_pkg::INSTR_W-1:0] ins);
        int tries;
        instr_i       = ins;
        instr_valid_i = 1'b1;
        tries         = 0;
        while (!instr_ready_o)
        begin
            @(negedge risc_clk);
            tries++;
            if (tries > 8)
            begin
                $display("instr_ready_o stayed low while an instruction waited");
                $display("Test failed");
                $fatal(1);
            end
        end
        @(negedge risc_clk);    // accepted at the rising edge in between
    endtask

    ////////////////////////////////////////////////////////////
    // memory model and ready monitor
    ////////////////////////////////////////////////////////////
    always @(negedge risc_clk)
    begin
        if (risc_rst && !instr_ready_o)
            ready_low++;
        if (dmem_req_o.rd_en)      // data valid before the capturing edge
            dmem_rdata_i = mem.exists(dmem_req_o.addr) ? mem[dmem_req_o.addr]
                                                       : fill_word(dmem_req_o.addr);
        if (dmem_req_o.wr_en)
        begin
            if (exp_stores.size() == 0)
            begin
                $display("store to %h with no store left in the golden file", dmem_req_o.addr);
                $display("Test failed");
                $fatal(1);
            end
            else
            begin
                exp_st = exp_stores.pop_front();
                check_val($sformatf("store %0d address", store_cnt), exp_st.addr,
                          dmem_req_o.addr);
                check_val($sformatf("store %0d data", store_cnt), exp_st.wdata,
                          dmem_req_o.wdata);
                mem[dmem_req_o.addr] = dmem_req_o.wdata;
                store_cnt++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        risc_rst      = 1'b0;       // low from time zero
        instr_i       = '0;
        instr_valid_i = 1'b0;
        dmem_rdata_i  = '0;
        seed          = 32'hcfb3_b5c4;
        store_cnt     = 0;
        ready_low     = 0;
        load_golden();
        n_stores   = exp_stores.size();
        exp_stalls = count_stalls();

        repeat (16) @(posedge risc_clk);
        @(negedge risc_clk);
        risc_rst = 1'b1;
        @(negedge risc_clk);
        check_val("reset ready", 1, bit_word(instr_ready_o));
        check_val("reset wr_en", 0, bit_word(dmem_req_o.wr_en));
        check_val("reset rd_en", 0, bit_word(dmem_req_o.rd_en));

        foreach (prog[i])
        begin
            if (i > 0 && prog[i-1][15:12] != risc_pkg::OP_LW)    // no gap after a load
            begin
                gap           = $unsigned($random(seed)) % 3;
                instr_valid_i = 1'b0;
                repeat (gap) @(negedge risc_clk);
            end
            send_instr(prog[i]);
        end
        instr_valid_i = 1'b0;

        waited = 0;
        while (store_cnt < n_stores)
        begin
            @(negedge risc_clk);
            waited++;
            if (waited > 50)
            begin
                $display("timeout, %0d of %0d stores seen", store_cnt, n_stores);
                $display("Test failed");
                $fatal(1);
            end
        end
        repeat (4) @(negedge risc_clk);    // four edges of pipeline depth let trailing ops retire

        check_val("ready low cycles", exp_stalls, ready_low);
        check_val("final carry", exp_carry, bit_word(carry_o));
        check_val("final zero", exp_zero, bit_word(zero_o));
        $display("Test passed");
        $finish;
    end

endmodule

// File: verification/risc_sva.sv
// protocol checks bound into every risc_top; exclusive enables, single-cycle stalls, quiet port in reset
module risc_sva (
    input logic                risc_clk,
    input logic                risc_rst,
    input logic                instr_ready_o,
    input risc_pkg::dmem_req_t dmem_req_o
);

    ////////////////////////////////////////////////////////////
    // data memory port
    ////////////////////////////////////////////////////////////
    a_rd_wr_excl: assert property (@(posedge risc_clk) disable iff (!risc_rst)
        !(dmem_req_o.wr_en && dmem_req_o.rd_en))
        else $error("dmem wr_en and rd_en high in the same cycle");

    a_quiet_in_rst: assert property (@(posedge risc_clk)
        !risc_rst |-> (!dmem_req_o.wr_en && !dmem_req_o.rd_en))    // async reset clears ex/mem
        else $error("dmem enable active during reset");

    // load-use costs exactly one cycle
    a_stall_once: assert property (@(posedge risc_clk) disable iff (!risc_rst)
        !instr_ready_o |=> instr_ready_o)
        else $error("instr_ready_o low for two cycles in a row");

endmodule

bind risc_top risc_sva i_sva (
    .risc_clk      (risc_clk),
    .risc_rst      (risc_rst),
    .instr_ready_o (instr_ready_o),
    .dmem_req_o    (dmem_req_o)
);

// File: rtl/risc_top.sv
// four-stage core without pc or branches; instructions enter on valid/ready, dmem has no stall
module risc_top (
    input  logic                             risc_clk,
    input  logic                             risc_rst,        // async, active low
    input  logic [risc_pkg::INSTR_W-1:0]     instr_i,
    input  logic                             instr_valid_i,
    output logic                             instr_ready_o,
    output risc_pkg::dmem_req_t              dmem_req_o,
    input  logic [risc_pkg::DATA_W-1:0]      dmem_rdata_i,    // valid the cycle rd_en is high
    output logic                             carry_o,
    output logic                             zero_o
);

    risc_pkg::decoded_t                  dec;        // decode stage
    risc_pkg::decoded_t                  id_ex;      // execute stage
    risc_pkg::ex_mem_t                   ex_mem;     // memory stage
    risc_pkg::wb_t                       wb;         // write-back record
    logic [risc_pkg::REG_ADDR_W-1:0]     rs1_addr;
    logic [risc_pkg::REG_ADDR_W-1:0]     rs2_addr;
    logic [risc_pkg::DATA_W-1:0]         rs1_data;
    logic [risc_pkg::DATA_W-1:0]         rs2_data;
    logic                                stall;      // load-use
    risc_pkg::fwd_sel_t                  fwd_a;
    risc_pkg::fwd_sel_t                  fwd_b;

    ////////////////////////////////////////////////////////////
    // front end
    ////////////////////////////////////////////////////////////
    instr_decoder i_decoder (
        .risc_clk      (risc_clk),
        .risc_rst      (risc_rst),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .stall_i       (stall),
        .instr_ready_o (instr_ready_o),
        .dec_o         (dec),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr)
    );

    reg_file i_reg_file (
        .risc_clk   (risc_clk),
        .risc_rst   (risc_rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_i       (wb),           // write port from wb stage
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    hazard_unit i_hazard (
        .dec_i    (dec),
        .id_ex_i  (id_ex),
        .ex_mem_i (ex_mem),
        .wb_i     (wb),
        .stall_o  (stall),
        .fwd_a_o  (fwd_a),
        .fwd_b_o  (fwd_b)
    );

    ////////////////////////////////////////////////////////////
    // back end
    ////////////////////////////////////////////////////////////
    exec_stage i_exec (
        .risc_clk   (risc_clk),
        .risc_rst   (risc_rst),
        .dec_i      (dec),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .stall_i    (stall),
        .fwd_a_i    (fwd_a),
        .fwd_b_i    (fwd_b),
        .wb_i       (wb),
        .id_ex_o    (id_ex),
        .ex_mem_o   (ex_mem),
        .carry_o    (carry_o),
        .zero_o     (zero_o)
    );

    mem_wb_stage i_mem_wb (
        .risc_clk     (risc_clk),
        .risc_rst     (risc_rst),
        .ex_mem_i     (ex_mem),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_req_o   (dmem_req_o),
        .wb_o         (wb)
    );

endmodule

// File: rtl/mem_wb_stage.sv
// dmem request straight from ex/mem; read data must be valid in the same cycle as rd_en
module mem_wb_stage (
    input  logic                           risc_clk,
    input  logic                           risc_rst,
    input  risc_pkg::ex_mem_t              ex_mem_i,
    input  logic [risc_pkg::DATA_W-1:0]    dmem_rdata_i,
    output risc_pkg::dmem_req_t            dmem_req_o,
    output risc_pkg::wb_t                  wb_o
);
    import risc_pkg::*;

    wb_t wb_d;

    ////////////////////////////////////////////////////////////
    // data memory request
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        dmem_req_o.wr_en = ex_mem_i.valid & ex_mem_i.mem_wr;   // bubbles never access
        dmem_req_o.rd_en = ex_mem_i.valid & ex_mem_i.mem_rd;
        dmem_req_o.addr  = ex_mem_i.result;
        dmem_req_o.wdata = ex_mem_i.store_data;
    end

    // load word or alu value
    always_comb
    begin
        wb_d.wr_en = ex_mem_i.valid & ex_mem_i.reg_wr;
        wb_d.rd    = ex_mem_i.rd;
        wb_d.data  = ex_mem_i.mem_rd ? dmem_rdata_i : ex_mem_i.result;
    end

    always_ff @(posedge risc_clk or negedge risc_rst)
    begin
        if (!risc_rst)
        begin
            wb_o <= '0;
        end
        else
        begin
            wb_o <= wb_d;   // reg file writes on the next edge
        end
    end

endmodule

// File: rtl/exec_stage.sv
// decode/execute register, forwarding, alu and flags, execute/memory register; flags hold on li/lw/sw/nop
module exec_stage (
    input  logic                           risc_clk,
    input  logic                           risc_rst,
    input  risc_pkg::decoded_t             dec_i,
    input  logic [risc_pkg::DATA_W-1:0]    rs1_data_i,
    input  logic [risc_pkg::DATA_W-1:0]    rs2_data_i,
    input  logic                           stall_i,
    input  risc_pkg::fwd_sel_t             fwd_a_i,
    input  risc_pkg::fwd_sel_t             fwd_b_i,
    input  risc_pkg::wb_t                  wb_i,
    output risc_pkg::decoded_t             id_ex_o,
    output risc_pkg::ex_mem_t              ex_mem_o,
    output logic                           carry_o,
    output logic                           zero_o
);
    import risc_pkg::*;

    logic [DATA_W-1:0] rs1_q;         // operands as read in decode
    logic [DATA_W-1:0] rs2_q;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b_reg;      // rs2 after forwarding, store data
    logic [DATA_W-1:0] op_b;
    logic [DATA_W:0]   sum;           // msb is carry out
    logic [DATA_W:0]   diff;          // msb is borrow
    logic [DATA_W-1:0] result;
    logic              carry_d;
    logic              flag_upd;
    ex_mem_t           ex_mem_d;

    function automatic logic [DATA_W-1:0] fwd_mux(input fwd_sel_t          sel,
                                                  input logic [DATA_W-1:0] reg_val,
                                                  input logic [DATA_W-1:0] mem_val,
                                                  input logic [DATA_W-1:0] wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // decode/execute register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge risc_clk or negedge risc_rst)
    begin
        if (!risc_rst)
        begin
            id_ex_o <= '0;
        end
        else
        begin
            id_ex_o       <= dec_i;
            id_ex_o.valid <= dec_i.valid & ~stall_i;   // bubble on load-use
        end
    end

    always_ff @(posedge risc_clk)
    begin
        rs1_q <= rs1_data_i;
        rs2_q <= rs2_data_i;
    end

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////
    assign op_a     = fwd_mux(fwd_a_i, rs1_q, ex_mem_o.result, wb_i.data);
    assign op_b_reg = fwd_mux(fwd_b_i, rs2_q, ex_mem_o.result, wb_i.data);
    assign op_b     = id_ex_o.use_imm ? id_ex_o.imm : op_b_reg;
    assign sum      = {1'b0, op_a} + {1'b0, op_b};
    assign diff     = {1'b0, op_a} - {1'b0, op_b};

    always_comb
    begin
        result   = sum[DATA_W-1:0];     // also lw/sw address
        carry_d  = carry_o;
        flag_upd = 1'b0;
        case (id_ex_o.op)
            OP_ADD, OP_ADDI:
            begin
                carry_d  = sum[DATA_W];
                flag_upd = 1'b1;
            end
            OP_SUB:
            begin
                result   = diff[DATA_W-1:0];
                carry_d  = ~diff[DATA_W];   // no borrow means a >= b
                flag_upd = 1'b1;
            end
            OP_AND, OP_OR, OP_XOR:
            begin
                if (id_ex_o.op == OP_AND)
                    result = op_a & op_b;
                else if (id_ex_o.op == OP_OR)
                    result = op_a | op_b;
                else
                    result = op_a ^ op_b;
                carry_d  = 1'b0;
                flag_upd = 1'b1;
            end
            OP_LI:   result = id_ex_o.imm;
            OP_NOP:  result = '0;
            default: result = sum[DATA_W-1:0];
        endcase
    end

    always_comb
    begin
        ex_mem_d            = '0;
        ex_mem_d.valid      = id_ex_o.valid;
        ex_mem_d.reg_wr     = id_ex_o.reg_wr;
        ex_mem_d.mem_rd     = id_ex_o.mem_rd;
        ex_mem_d.mem_wr     = id_ex_o.mem_wr;
        ex_mem_d.rd         = id_ex_o.rd;
        ex_mem_d.result     = result;
        ex_mem_d.store_data = op_b_reg;
    end

    ////////////////////////////////////////////////////////////
    // execute/memory register and flags
    ////////////////////////////////////////////////////////////
    always_ff @(posedge risc_clk or negedge risc_rst)
    begin
        if (!risc_rst)
        begin
            ex_mem_o <= '0;
            carry_o  <= 1'b0;
            zero_o   <= 1'b0;
        end
        else
        begin
            ex_mem_o <= ex_mem_d;
            if (id_ex_o.valid && flag_upd)     // six alu ops only
            begin
                carry_o <= carry_d;
                zero_o  <= (result == '0);
            end
        end
    end

endmodule

// File: rtl/hazard_unit.sv
// combinational load-use stall and operand forward selects; a load result is never forwarded from mem
module hazard_unit (
    input  risc_pkg::decoded_t     dec_i,      // decode stage
    input  risc_pkg::decoded_t     id_ex_i,    // execute stage
    input  risc_pkg::ex_mem_t      ex_mem_i,
    input  risc_pkg::wb_t          wb_i,
    output logic                   stall_o,
    output risc_pkg::fwd_sel_t     fwd_a_o,
    output risc_pkg::fwd_sel_t     fwd_b_o
);
    import risc_pkg::*;

    logic ld_in_ex;     // load in execute with a real target
    logic rs1_hit;
    logic rs2_hit;

    // newest producer wins, mem before wb
    function automatic fwd_sel_t pick(input logic [REG_ADDR_W-1:0] src,
                                      input ex_mem_t               em,
                                      input wb_t                   wb);
        if (src == '0)
            return FWD_NONE;
        else if (em.valid && em.reg_wr && !em.mem_rd && em.rd == src)
            return FWD_MEM;
        else if (wb.wr_en && wb.rd == src)
            return FWD_WB;
        else
            return FWD_NONE;
    endfunction

    assign ld_in_ex = id_ex_i.valid && id_ex_i.mem_rd && id_ex_i.rd != '0;
    assign rs1_hit  = dec_i.uses_rs1 && dec_i.rs1 == id_ex_i.rd;
    assign rs2_hit  = dec_i.uses_rs2 && dec_i.rs2 == id_ex_i.rd;
    assign stall_o  = ld_in_ex && dec_i.valid && (rs1_hit || rs2_hit);   // one cycle only

    assign fwd_a_o = pick(id_ex_i.rs1, ex_mem_i, wb_i);
    assign fwd_b_o = pick(id_ex_i.rs2, ex_mem_i, wb_i);    // also store data

endmodule

// File: rtl/reg_file.sv
// eight 32-bit registers, two combinational reads, one write; r0 is hardwired to zero
module reg_file (
    input  logic                              risc_clk,
    input  logic                              risc_rst,
    input  logic [risc_pkg::REG_ADDR_W-1:0]   rs1_addr_i,
    input  logic [risc_pkg::REG_ADDR_W-1:0]   rs2_addr_i,
    input  risc_pkg::wb_t                     wb_i,
    output logic [risc_pkg::DATA_W-1:0]       rs1_data_o,
    output logic [risc_pkg::DATA_W-1:0]       rs2_data_o
);
    import risc_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    // read with bypass of the word being written this cycle
    function automatic logic [DATA_W-1:0] rd_port(input logic [REG_ADDR_W-1:0] addr,
                                                  input wb_t                   wb,
                                                  input logic [DATA_W-1:0]     stored);
        if (addr == '0)
            return '0;
        else if (wb.wr_en && wb.rd == addr)
            return wb.data;
        else
            return stored;
    endfunction

    always_ff @(posedge risc_clk or negedge risc_rst)
    begin
        if (!risc_rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_i.wr_en && wb_i.rd != '0)      // r0 stays zero
        begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign rs1_data_o = rd_port(rs1_addr_i, wb_i, regs[rs1_addr_i]);
    assign rs2_data_o = rd_port(rs2_addr_i, wb_i, regs[rs2_addr_i]);

endmodule

// File: rtl/instr_decoder.sv
// instruction register plus decode; undefined opcodes become nop, holds its word while stalled
module instr_decoder (
    input  logic                              risc_clk,
    input  logic                              risc_rst,
    input  logic [risc_pkg::INSTR_W-1:0]      instr_i,
    input  logic                              instr_valid_i,
    input  logic                              stall_i,
    output logic                              instr_ready_o,
    output risc_pkg::decoded_t                dec_o,
    output logic [risc_pkg::REG_ADDR_W-1:0]   rs1_addr_o,
    output logic [risc_pkg::REG_ADDR_W-1:0]   rs2_addr_o
);
    import risc_pkg::*;

    logic                ir_valid;   // decode slot holds an instruction
    logic [INSTR_W-1:0]  ir;         // instruction register
    logic [DATA_W-1:0]   imm6_sx;
    logic [DATA_W-1:0]   imm9_sx;

    assign instr_ready_o = ~stall_i;    // only back-pressure source

    always_ff @(posedge risc_clk or negedge risc_rst)
    begin
        if (!risc_rst)
        begin
            ir_valid <= 1'b0;
        end
        else if (!stall_i)
        begin
            ir_valid <= instr_valid_i;     // low valid lets a bubble in
        end
    end

    always_ff @(posedge risc_clk)
    begin
        if (!stall_i && instr_valid_i)
        begin
            ir <= instr_i;
        end
    end

    assign imm6_sx = {{(DATA_W-IMM6_W){ir[IMM6_W-1]}}, ir[IMM6_W-1:0]};
    assign imm9_sx = {{(DATA_W-IMM9_W){ir[IMM9_W-1]}}, ir[IMM9_W-1:0]};

    ////////////////////////////////////////////////////////////
    // field decode
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        dec_o       = '0;
        dec_o.valid = ir_valid;
        dec_o.op    = OP_NOP;
        dec_o.rd    = ir[11:9];
        dec_o.rs1   = ir[8:6];
        dec_o.rs2   = ir[5:3];
        dec_o.imm   = imm6_sx;
        case (ir[INSTR_W-1 -: OPC_W])
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
            begin
                dec_o.op       = opcode_t'(ir[INSTR_W-1 -: OPC_W]);
                dec_o.reg_wr   = 1'b1;
                dec_o.uses_rs1 = 1'b1;
                dec_o.uses_rs2 = 1'b1;
            end
            OP_ADDI:
            begin
                dec_o.op       = OP_ADDI;
                dec_o.reg_wr   = 1'b1;
                dec_o.use_imm  = 1'b1;
                dec_o.uses_rs1 = 1'b1;
            end
            OP_LI:
            begin
                dec_o.op      = OP_LI;
                dec_o.reg_wr  = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm9_sx;    // rs fields overlap imm9, not read
            end
            OP_LW:
            begin
                dec_o.op       = OP_LW;
                dec_o.reg_wr   = 1'b1;
                dec_o.mem_rd   = 1'b1;
                dec_o.use_imm  = 1'b1;
                dec_o.uses_rs1 = 1'b1;      // base
            end
            OP_SW:
            begin
                dec_o.op       = OP_SW;
                dec_o.mem_wr   = 1'b1;
                dec_o.use_imm  = 1'b1;
                dec_o.uses_rs1 = 1'b1;      // base
                dec_o.uses_rs2 = 1'b1;
                dec_o.rs2      = ir[11:9];  // store data sits in the rd field
            end
            default:
            begin
                dec_o.op = OP_NOP;          // nop and undefined codes
            end
        endcase
    end

    assign rs1_addr_o = dec_o.rs1;
    assign rs2_addr_o = dec_o.rs2;

endmodule

// File: rtl/risc_pkg.sv
// shared widths, opcodes and stage records; 16-bit instructions, 32-bit data, eight registers
package risc_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int DATA_W     = 32;    // datapath and memory word
    localparam int INSTR_W    = 16;    // instruction word
    localparam int REG_ADDR_W = 3;     // register index
    localparam int NUM_REGS   = 8;     // r0..r7, r0 reads zero
    localparam int IMM6_W     = 6;     // short immediate, bits 5..0
    localparam int IMM9_W     = 9;     // li immediate, bits 8..0
    localparam int OPC_W      = 4;     // opcode, bits 15..12

    // opcode map, codes 10..15 are treated as nop
    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LI   = 4'd7,
        OP_LW   = 4'd8,
        OP_SW   = 4'd9
    } opcode_t;

    // operand source for execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,    // register file value
        FWD_MEM  = 2'd1,    // execute/memory result
        FWD_WB   = 2'd2     // write-back data
    } fwd_sel_t;

    ////////////////////////////////////////////////////////////
    // stage records
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                  valid;
        opcode_t               op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;       // store data register for sw
        logic [DATA_W-1:0]     imm;       // already sign extended
        logic                  reg_wr;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  use_imm;   // alu b operand from imm
        logic                  uses_rs1;
        logic                  uses_rs2;
    } decoded_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_wr;
        logic                  mem_rd;
        logic                  mem_wr;
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     result;      // alu value or address
        logic [DATA_W-1:0]     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic              wr_en;
        logic              rd_en;
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     data;
    } wb_t;

endpackage
